/* Makefile */
TOP       ?= tb_core
LOG       ?= sim.log
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(VERILATOR), run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f list.f
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* hw/bus_pkg.sv */
package bus_pkg;

    // master side of the axi4-lite port
    typedef struct packed {
        logic           awvalid;
        isa_pkg::addr_t awaddr;
        logic           wvalid;
        isa_pkg::word_t wdata;
        logic [3:0]     wstrb;
        logic           bready;
        logic           arvalid;
        isa_pkg::addr_t araddr;
        logic           rready;
    } axi_req_t;

    // slave side of the axi4-lite port
    typedef struct packed {
        logic           awready;
        logic           wready;
        logic           bvalid;
        logic [1:0]     bresp;
        logic           arready;
        logic           rvalid;
        isa_pkg::word_t rdata;
        logic [1:0]     rresp;
    } axi_rsp_t;

    // request from the controller to the load-store unit
    typedef struct packed {
        logic               valid;
        logic               write;
        isa_pkg::addr_t     addr;
        isa_pkg::word_t     wdata;
        isa_pkg::mem_size_t size;
        logic               unsigned_load;
    } mem_req_t;

endpackage

/* hw/core_ctrl.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module core_ctrl (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               mem_done,
    input  isa_pkg::word_t     mem_rdata,
    input  isa_pkg::decoded_t  dec,
    input  isa_pkg::word_t     rs2_data,
    input  isa_pkg::word_t     alu_result,
    input  logic               branch_taken,
    input  isa_pkg::addr_t     target,
    output bus_pkg::mem_req_t  mem_req,
    output logic               fetch_sel,
    output isa_pkg::word_t     inst,
    output logic               rd_we,
    output isa_pkg::reg_idx_t  rd_idx,
    output isa_pkg::word_t     rd_data,
    output isa_pkg::addr_t     pc,
    output logic               halted
);
    import isa_pkg::*;

    typedef enum logic [2:0] {IDLE, FETCH, EXEC, MEM, WB, HALT} state_t;

    state_t state;
    addr_t  pc_plus4;
    addr_t  next_pc;

    assign pc_plus4 = pc + 32'd4;
    assign next_pc  = (branch_taken || dec.is_jal || dec.is_jalr) ? target : pc_plus4;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
            pc    <= `RESET_PC;
        end else begin
            case (state)
                IDLE:  state <= FETCH;
                FETCH: begin
                    if (mem_done) begin
                        state <= EXEC;
                    end
                end
                EXEC: begin
                    if (dec.halt) begin
                        state <= HALT;
                    end else if (dec.is_load || dec.is_store) begin
                        state <= MEM;
                    end else begin
                        state <= WB;
                    end
                end
                MEM: begin
                    if (mem_done) begin
                        state <= WB;
                    end
                end
                WB: begin
                    pc    <= next_pc;
                    state <= FETCH;
                end
                default: state <= HALT;
            endcase
        end
    end

    // instruction register
    always_ff @(posedge clk) begin
        if (state == FETCH && mem_done) begin
            inst <= mem_rdata;
        end
    end

    // fetch uses the pc, data access the effective address
    assign fetch_sel             = (state == FETCH);
    assign mem_req.valid         = (state == FETCH) || (state == MEM);
    assign mem_req.write         = dec.is_store;
    assign mem_req.addr          = fetch_sel ? pc : alu_result;
    assign mem_req.wdata         = rs2_data;
    assign mem_req.size          = dec.mem_size;
    assign mem_req.unsigned_load = dec.load_unsigned;

    assign rd_we  = (state == WB) && dec.reg_write;
    assign rd_idx = dec.rd;

    always_comb begin
        if (dec.is_load) begin
            rd_data = mem_rdata;
        end else if (dec.is_jal || dec.is_jalr) begin
            rd_data = pc_plus4;
        end else if (dec.is_lui) begin
            rd_data = dec.imm;
        end else begin
            rd_data = alu_result;
        end
    end

    assign halted = (state == HALT);

endmodule

/* hw/exu.sv */
`timescale 1ns/1ps

module exu (
    input  isa_pkg::decoded_t dec,
    input  isa_pkg::word_t    rs1_data,
    input  isa_pkg::word_t    rs2_data,
    input  isa_pkg::addr_t    pc,
    output isa_pkg::word_t    alu_result,
    output logic              branch_taken,
    output isa_pkg::addr_t    target
);
    import isa_pkg::*;

    word_t      op_a;
    word_t      op_b;
    logic [4:0] shamt;
    logic       cond;
    addr_t      jalr_sum;

    assign op_a  = dec.use_pc_a ? pc : rs1_data;
    assign op_b  = dec.use_imm ? dec.imm : rs2_data;
    assign shamt = op_b[4:0];

    // loads and stores come out as the effective address
    always_comb begin
        case (dec.alu_op)
            ALU_ADD:  alu_result = op_a + op_b;
            ALU_SUB:  alu_result = op_a - op_b;
            ALU_SLL:  alu_result = op_a << shamt;
            ALU_SLT:  alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_result = {31'b0, op_a < op_b};
            ALU_XOR:  alu_result = op_a ^ op_b;
            ALU_SRL:  alu_result = op_a >> shamt;
            ALU_SRA:  alu_result = $signed(op_a) >>> shamt;
            ALU_OR:   alu_result = op_a | op_b;
            default:  alu_result = op_a & op_b;
        endcase
    end

    always_comb begin
        case (dec.branch_funct)
            3'b000:  cond = (rs1_data == rs2_data);
            3'b001:  cond = (rs1_data != rs2_data);
            3'b100:  cond = $signed(rs1_data) < $signed(rs2_data);
            3'b101:  cond = $signed(rs1_data) >= $signed(rs2_data);
            3'b110:  cond = rs1_data < rs2_data;
            3'b111:  cond = rs1_data >= rs2_data;
            default: cond = 1'b0;
        endcase
    end

    assign branch_taken = dec.is_branch && cond;

    assign jalr_sum = rs1_data + dec.imm;
    assign target   = dec.is_jalr ? {jalr_sum[31:1], 1'b0} : pc + dec.imm;

endmodule

/* hw/idu.sv */
`timescale 1ns/1ps

module idu (
    input  isa_pkg::word_t    inst,
    output isa_pkg::decoded_t dec
);
    import isa_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    alu_op_t    op_sel;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    // funct7 bit 5 picks sub and sra
    assign alt    = inst[30];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        case (funct3)
            3'b000:  op_sel = (opcode == 7'b0110011 && alt) ? ALU_SUB : ALU_ADD;
            3'b001:  op_sel = ALU_SLL;
            3'b010:  op_sel = ALU_SLT;
            3'b011:  op_sel = ALU_SLTU;
            3'b100:  op_sel = ALU_XOR;
            3'b101:  op_sel = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op_sel = ALU_OR;
            default: op_sel = ALU_AND;
        endcase
    end

    always_comb begin
        dec     = '0;
        // rv32e only has four register index bits
        dec.rs1 = inst[18:15];
        dec.rs2 = inst[23:20];
        dec.rd  = inst[10:7];
        case (opcode)
            7'b0110111: begin
                dec.imm       = imm_u;
                dec.reg_write = 1'b1;
                dec.is_lui    = 1'b1;
            end
            7'b0010111: begin
                dec.imm       = imm_u;
                dec.reg_write = 1'b1;
                dec.use_pc_a  = 1'b1;
                dec.use_imm   = 1'b1;
            end
            7'b1101111: begin
                dec.imm       = imm_j;
                dec.reg_write = 1'b1;
                dec.is_jal    = 1'b1;
            end
            7'b1100111: begin
                dec.imm       = imm_i;
                dec.reg_write = 1'b1;
                dec.is_jalr   = 1'b1;
            end
            7'b1100011: begin
                dec.imm          = imm_b;
                dec.is_branch    = 1'b1;
                dec.branch_funct = funct3;
            end
            7'b0000011: begin
                dec.imm           = imm_i;
                dec.reg_write     = 1'b1;
                dec.is_load       = 1'b1;
                dec.use_imm       = 1'b1;
                dec.mem_size      = funct3[1:0];
                dec.load_unsigned = funct3[2];
            end
            7'b0100011: begin
                dec.imm      = imm_s;
                dec.is_store = 1'b1;
                dec.use_imm  = 1'b1;
                dec.mem_size = funct3[1:0];
            end
            7'b0010011: begin
                dec.imm       = imm_i;
                dec.reg_write = 1'b1;
                dec.use_imm   = 1'b1;
                dec.alu_op    = op_sel;
            end
            7'b0110011: begin
                dec.reg_write = 1'b1;
                dec.alu_op    = op_sel;
            end
            7'b1110011: begin
                // ebreak halts, ecall falls through as a nop
                dec.halt = (inst[31:7] == 25'h0002000);
            end
            default: ;
        endcase
    end

endmodule

/* hw/isa_pkg.sv */
`include "core_defines.svh"

package isa_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [`XLEN-1:0] addr_t;
    typedef logic [`REG_AW-1:0] reg_idx_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    // 0 byte, 1 half-word, 2 word
    typedef logic [1:0] mem_size_t;

    typedef struct packed {
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        reg_idx_t  rd;
        word_t     imm;
        alu_op_t   alu_op;
        logic      use_imm;
        logic      use_pc_a;
        logic      reg_write;
        logic      is_load;
        logic      is_store;
        logic      load_unsigned;
        logic      is_branch;
        logic      is_jal;
        logic      is_jalr;
        logic      is_lui;
        logic      halt;
        mem_size_t mem_size;
        // funct3 of the branch, selects the compare
        logic [2:0] branch_funct;
    } decoded_t;

endpackage

/* hw/lsu.sv */
`timescale 1ns/1ps

module lsu (
    input  logic              clk,
    input  logic              rst_n,
    input  bus_pkg::mem_req_t mem_req,
    input  logic              fetch_sel,
    output logic              mem_done,
    output isa_pkg::word_t    mem_rdata,
    output bus_pkg::axi_req_t m_axi_req,
    input  bus_pkg::axi_rsp_t m_axi_rsp
);
    import isa_pkg::*;

    typedef enum logic [1:0] {IDLE, ADDR, RESP, DONE} state_t;

    state_t    state;
    logic      accept;
    logic      sel_write;
    mem_size_t sel_size;
    word_t     sel_wdata;
    logic [3:0] sel_strb;
    addr_t     addr_q;
    logic      write_q;
    mem_size_t size_q;
    logic      unsigned_q;
    word_t     wdata_q;
    logic [3:0] strb_q;
    logic      aw_done;
    logic      w_done;
    logic      aw_fire;
    logic      w_fire;
    logic      ar_fire;
    logic      b_fire;
    logic      r_fire;
    word_t     shifted;
    word_t     load_ext;

    // arbiter, a fetch is always a word read
    assign sel_write = fetch_sel ? 1'b0 : mem_req.write;
    assign sel_size  = fetch_sel ? 2'd2 : mem_req.size;
    assign accept    = (state == IDLE) && mem_req.valid;

    // replicate store data over the byte lanes
    always_comb begin
        case (sel_size)
            2'd0: begin
                sel_wdata = {4{mem_req.wdata[7:0]}};
                sel_strb  = 4'b0001 << mem_req.addr[1:0];
            end
            2'd1: begin
                sel_wdata = {2{mem_req.wdata[15:0]}};
                sel_strb  = 4'b0011 << {mem_req.addr[1], 1'b0};
            end
            default: begin
                sel_wdata = mem_req.wdata;
                sel_strb  = 4'b1111;
            end
        endcase
    end

    assign aw_fire = m_axi_req.awvalid && m_axi_rsp.awready;
    assign w_fire  = m_axi_req.wvalid && m_axi_rsp.wready;
    assign ar_fire = m_axi_req.arvalid && m_axi_rsp.arready;
    assign b_fire  = m_axi_req.bready && m_axi_rsp.bvalid;
    assign r_fire  = m_axi_req.rready && m_axi_rsp.rvalid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= IDLE;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        state   <= ADDR;
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                    end
                end
                ADDR: begin
                    aw_done <= aw_done | aw_fire;
                    w_done  <= w_done | w_fire;
                    if (write_q ? ((aw_done || aw_fire) && (w_done || w_fire)) : ar_fire) begin
                        state <= RESP;
                    end
                end
                RESP: begin
                    if (b_fire || r_fire) begin
                        state <= DONE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q     <= mem_req.addr;
            write_q    <= sel_write;
            size_q     <= sel_size;
            unsigned_q <= mem_req.unsigned_load;
            wdata_q    <= sel_wdata;
            strb_q     <= sel_strb;
        end
        if (r_fire) begin
            mem_rdata <= load_ext;
        end
    end

    // pull the addressed lane down, then extend
    assign shifted = m_axi_rsp.rdata >> {addr_q[1:0], 3'b000};

    always_comb begin
        case (size_q)
            2'd0:    load_ext = {{24{shifted[7] & ~unsigned_q}}, shifted[7:0]};
            2'd1:    load_ext = {{16{shifted[15] & ~unsigned_q}}, shifted[15:0]};
            default: load_ext = shifted;
        endcase
    end

    always_comb begin
        m_axi_req         = '0;
        m_axi_req.awaddr  = {addr_q[31:2], 2'b00};
        m_axi_req.araddr  = {addr_q[31:2], 2'b00};
        m_axi_req.wdata   = wdata_q;
        m_axi_req.wstrb   = strb_q;
        m_axi_req.awvalid = (state == ADDR) && write_q && !aw_done;
        m_axi_req.wvalid  = (state == ADDR) && write_q && !w_done;
        m_axi_req.arvalid = (state == ADDR) && !write_q;
        m_axi_req.bready  = (state == RESP) && write_q;
        m_axi_req.rready  = (state == RESP) && !write_q;
    end

    assign mem_done = (state == DONE);

endmodule

/* hw/regfile.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module regfile (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              we,
    input  isa_pkg::reg_idx_t waddr,
    input  isa_pkg::word_t    wdata,
    input  isa_pkg::reg_idx_t raddr1,
    input  isa_pkg::reg_idx_t raddr2,
    output isa_pkg::word_t    rdata1,
    output isa_pkg::word_t    rdata2
);
    import isa_pkg::*;

    word_t regs [`REG_COUNT];

    // x0 is cleared by reset and never written
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

endmodule

/* hw/rv_core.sv */
`timescale 1ns/1ps

module rv_core (
    input  logic              clk,
    input  logic              rst_n,
    output bus_pkg::axi_req_t m_axi_req,
    input  bus_pkg::axi_rsp_t m_axi_rsp,
    output logic              halted,
    output isa_pkg::addr_t    pc
);
    import isa_pkg::*;
    import bus_pkg::*;

    decoded_t dec;
    word_t    inst;
    mem_req_t mem_req;
    logic     fetch_sel;
    logic     mem_done;
    word_t    mem_rdata;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    alu_result;
    logic     branch_taken;
    addr_t    target;
    logic     rd_we;
    reg_idx_t rd_idx;
    word_t    rd_data;

    core_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_done     (mem_done),
        .mem_rdata    (mem_rdata),
        .dec          (dec),
        .rs2_data     (rs2_data),
        .alu_result   (alu_result),
        .branch_taken (branch_taken),
        .target       (target),
        .mem_req      (mem_req),
        .fetch_sel    (fetch_sel),
        .inst         (inst),
        .rd_we        (rd_we),
        .rd_idx       (rd_idx),
        .rd_data      (rd_data),
        .pc           (pc),
        .halted       (halted)
    );

    idu u_idu (
        .inst (inst),
        .dec  (dec)
    );

    regfile u_regfile (
        .clk    (clk),
        .rst_n  (rst_n),
        .we     (rd_we),
        .waddr  (rd_idx),
        .wdata  (rd_data),
        .raddr1 (dec.rs1),
        .raddr2 (dec.rs2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    exu u_exu (
        .dec          (dec),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .pc           (pc),
        .alu_result   (alu_result),
        .branch_taken (branch_taken),
        .target       (target)
    );

    lsu u_lsu (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_req   (mem_req),
        .fetch_sel (fetch_sel),
        .mem_done  (mem_done),
        .mem_rdata (mem_rdata),
        .m_axi_req (m_axi_req),
        .m_axi_rsp (m_axi_rsp)
    );

endmodule

/* include/core_defines.svh */
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// address of the first fetch after reset
`define RESET_PC 32'h0000_0000

// data path and address width
`define XLEN 32

// rv32e keeps sixteen integer registers
`define REG_COUNT 16
`define REG_AW 4

`endif

/* list.f */
+incdir+include
hw/isa_pkg.sv
hw/bus_pkg.sv
hw/core_ctrl.sv
hw/idu.sv
hw/regfile.sv
hw/exu.sv
hw/lsu.sv
hw/rv_core.sv
test/axi_mem.sv
test/tb_core.sv

/* test/axi_mem.sv */
`timescale 1ns/1ps

module axi_mem (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              delay_en,
    input  logic              fill,
    input  logic              load_en,
    input  isa_pkg::addr_t    load_addr,
    input  isa_pkg::word_t    load_data,
    input  bus_pkg::axi_req_t axi_req,
    output bus_pkg::axi_rsp_t axi_rsp
);
    import isa_pkg::*;
    import bus_pkg::*;

    // 1 KiB, word indexed by address bits 9:2
    word_t      mem [0:255];
    integer     seed = 5146;
    word_t      rand_q;
    logic [1:0] ar_wait;
    logic [1:0] aw_wait;
    logic [1:0] w_wait;
    logic       aw_got;
    logic       w_got;
    addr_t      awaddr_q;
    word_t      wdata_q;
    logic [3:0] strb_q;
    logic       do_write;

    always_ff @(posedge clk) begin
        rand_q <= $random(seed);
    end

    assign do_write = aw_got && w_got && !axi_rsp.bvalid;

    // backdoor fill and load share the array with bus writes
    always_ff @(posedge clk) begin
        if (fill) begin
            for (int i = 0; i < 256; i++) begin
                mem[i] <= 32'(i * 4) ^ 32'ha5a5_0000;
            end
        end else if (load_en) begin
            mem[load_addr[9:2]] <= load_data;
        end else if (do_write) begin
            for (int b = 0; b < 4; b++) begin
                if (strb_q[b]) begin
                    mem[awaddr_q[9:2]][8*b +: 8] <= wdata_q[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            axi_rsp <= '0;
            ar_wait <= 2'd0;
            aw_wait <= 2'd0;
            w_wait  <= 2'd0;
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
        end else begin
            // read address and data
            if (axi_req.arvalid && axi_rsp.arready) begin
                axi_rsp.arready <= 1'b0;
                axi_rsp.rvalid  <= 1'b1;
                axi_rsp.rdata   <= mem[axi_req.araddr[9:2]];
            end else if (axi_req.arvalid && !axi_rsp.rvalid) begin
                if (ar_wait == 2'd0) begin
                    axi_rsp.arready <= 1'b1;
                end else begin
                    ar_wait <= ar_wait - 2'd1;
                end
            end
            if (axi_rsp.rvalid && axi_req.rready) begin
                axi_rsp.rvalid <= 1'b0;
                ar_wait        <= delay_en ? rand_q[1:0] : 2'd0;
            end
            // write address
            if (axi_req.awvalid && axi_rsp.awready) begin
                axi_rsp.awready <= 1'b0;
                aw_got          <= 1'b1;
                awaddr_q        <= axi_req.awaddr;
            end else if (axi_req.awvalid && !aw_got) begin
                if (aw_wait == 2'd0) begin
                    axi_rsp.awready <= 1'b1;
                end else begin
                    aw_wait <= aw_wait - 2'd1;
                end
            end
            // write data
            if (axi_req.wvalid && axi_rsp.wready) begin
                axi_rsp.wready <= 1'b0;
                w_got          <= 1'b1;
                wdata_q        <= axi_req.wdata;
                strb_q         <= axi_req.wstrb;
            end else if (axi_req.wvalid && !w_got) begin
                if (w_wait == 2'd0) begin
                    axi_rsp.wready <= 1'b1;
                end else begin
                    w_wait <= w_wait - 2'd1;
                end
            end
            if (do_write) begin
                axi_rsp.bvalid <= 1'b1;
                aw_got         <= 1'b0;
                w_got          <= 1'b0;
            end
            if (axi_rsp.bvalid && axi_req.bready) begin
                axi_rsp.bvalid <= 1'b0;
                aw_wait        <= delay_en ? rand_q[3:2] : 2'd0;
                w_wait         <= delay_en ? rand_q[5:4] : 2'd0;
            end
        end
    end

endmodule

/* test/tb_core.sv */
`timescale 1ns/1ps

module tb_core;
    import isa_pkg::*;
    import bus_pkg::*;

    localparam logic [6:0] OP_IMM = 7'b0010011;
    localparam logic [6:0] LOAD   = 7'b0000011;
    localparam word_t      EBREAK = 32'h0010_0073;

    // seven program runs, each with its load phase, plus the halt watch
    localparam int RUN_COUNT   = 7;
    localparam int RUN_CYCLES  = 400;
    localparam int LOAD_CYCLES = 40;
    localparam int CYCLE_LIMIT = RUN_COUNT * (RUN_CYCLES + LOAD_CYCLES) + 50;

    logic     clk;
    logic     rst_n;
    logic     halted;
    addr_t    pc;
    axi_req_t axi_req;
    axi_rsp_t axi_rsp;
    logic     delay_en;
    logic     fill;
    logic     load_en;
    addr_t    load_addr;
    word_t    load_data;
    int       cycle_count;
    int       errors;
    int       checks;
    int       tests;
    word_t    prog [$];

    rv_core DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .m_axi_req (axi_req),
        .m_axi_rsp (axi_rsp),
        .halted    (halted),
        .pc        (pc)
    );

    axi_mem mem_model (
        .clk       (clk),
        .rst_n     (rst_n),
        .delay_en  (delay_en),
        .fill      (fill),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .axi_req   (axi_req),
        .axi_rsp   (axi_rsp)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the core did not finish within %0d cycles", CYCLE_LIMIT);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    function automatic word_t r_type(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic word_t i_type(int imm, int rs1, int f3, int rd, logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic word_t s_type(int imm, int rs2, int rs1, int f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t b_type(int imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                7'b1100011};
    endfunction

    function automatic word_t j_type(int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic word_t mem_word(addr_t a);
        return mem_model.mem[a[9:2]];
    endfunction

    task automatic check_word(string name, word_t got, word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_pc(addr_t got, addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED pc got %h expected %h", got, exp);
        end
    endtask

    // hold reset, fill memory, write the program and the presets
    task automatic begin_load();
        @(negedge clk);
        rst_n = 1'b0;
        fill  = 1'b1;
        @(negedge clk);
        fill = 1'b0;
        for (int i = 0; i < prog.size(); i++) begin
            put_word(addr_t'(i * 4), prog[i]);
        end
    endtask

    task automatic put_word(addr_t a, word_t d);
        @(negedge clk);
        load_en   = 1'b1;
        load_addr = a;
        load_data = d;
    endtask

    task automatic run_program();
        @(negedge clk);
        load_en = 1'b0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        while (!halted) begin
            @(negedge clk);
        end
        check_pc(pc, addr_t'(4 * (prog.size() - 1)));
    endtask

    task automatic arith_run();
        word_t a;
        word_t b;
        word_t exp [10];
        a = 32'h123;
        b = 32'hffff_fff9;
        prog = {};
        prog.push_back(i_type(12'h123, 0, 0, 1, OP_IMM));
        prog.push_back(i_type(-7, 0, 0, 2, OP_IMM));
        prog.push_back(r_type(7'h00, 2, 1, 0, 3));
        prog.push_back(r_type(7'h20, 2, 1, 0, 4));
        prog.push_back(i_type(12'h004, 1, 1, 5, OP_IMM));
        prog.push_back(i_type(12'h401, 2, 5, 6, OP_IMM));
        prog.push_back(i_type(12'h01c, 2, 5, 7, OP_IMM));
        prog.push_back(r_type(7'h00, 1, 2, 2, 8));
        prog.push_back(r_type(7'h00, 1, 2, 3, 9));
        prog.push_back(r_type(7'h00, 2, 1, 4, 10));
        prog.push_back(r_type(7'h00, 2, 1, 6, 11));
        prog.push_back(i_type(12'h0f0, 1, 7, 12, OP_IMM));
        for (int k = 3; k <= 12; k++) begin
            prog.push_back(s_type(12'h200 + 4 * (k - 3), k, 0, 2));
        end
        prog.push_back(EBREAK);
        begin_load();
        run_program();
        exp[0] = a + b;
        exp[1] = a - b;
        exp[2] = a << 4;
        exp[3] = $signed(b) >>> 1;
        exp[4] = b >> 28;
        exp[5] = ($signed(b) < $signed(a)) ? 32'd1 : 32'd0;
        exp[6] = (b < a) ? 32'd1 : 32'd0;
        exp[7] = a ^ b;
        exp[8] = a | b;
        exp[9] = a & 32'h0f0;
        for (int k = 0; k < 10; k++) begin
            check_word($sformatf("arith_word%0d", k), mem_word(addr_t'(32'h200 + 4 * k)), exp[k]);
        end
    endtask

    task automatic control_run();
        word_t sum;
        sum = 0;
        for (int i = 1; i <= 10; i++) begin
            sum = sum + word_t'(i);
        end
        prog = {};
        prog.push_back(i_type(0, 0, 0, 1, OP_IMM));
        prog.push_back(i_type(1, 0, 0, 2, OP_IMM));
        prog.push_back(i_type(11, 0, 0, 3, OP_IMM));
        // loop body at 0x0c
        prog.push_back(r_type(7'h00, 2, 1, 0, 1));
        prog.push_back(i_type(1, 2, 0, 2, OP_IMM));
        prog.push_back(b_type(-8, 3, 2, 1));
        // call at 0x18 into the routine at 0x28
        prog.push_back(j_type(16, 4));
        prog.push_back(s_type(12'h200, 1, 0, 2));
        prog.push_back(s_type(12'h204, 4, 0, 2));
        prog.push_back(EBREAK);
        // routine leaves its link value behind before returning
        prog.push_back(s_type(12'h208, 4, 0, 2));
        prog.push_back(i_type(0, 4, 0, 0, 7'b1100111));
        begin_load();
        // ebreak sits at 0x24, not at the last word
        prog = prog[0:9];
        run_program();
        check_word("loop_sum", mem_word(32'h200), sum);
        check_word("link", mem_word(32'h204), 32'h18 + 32'd4);
        check_word("routine", mem_word(32'h208), 32'h18 + 32'd4);
    endtask

    task automatic mem_size_run();
        word_t pre [3];
        word_t lb;
        word_t hw;
        pre[0] = 32'h1122_3344;
        pre[1] = 32'h5566_7788;
        pre[2] = 32'h8000_0080;
        prog = {};
        prog.push_back(i_type(12'h0ab, 0, 0, 1, OP_IMM));
        prog.push_back(s_type(12'h201, 1, 0, 0));
        prog.push_back(i_type(12'h5cd, 0, 0, 2, OP_IMM));
        prog.push_back(s_type(12'h206, 2, 0, 1));
        prog.push_back(i_type(12'h20c, 0, 0, 3, LOAD));
        prog.push_back(i_type(12'h20c, 0, 4, 4, LOAD));
        prog.push_back(i_type(12'h20e, 0, 1, 5, LOAD));
        prog.push_back(i_type(12'h20e, 0, 5, 6, LOAD));
        for (int k = 3; k <= 6; k++) begin
            prog.push_back(s_type(12'h210 + 4 * (k - 3), k, 0, 2));
        end
        prog.push_back(EBREAK);
        begin_load();
        put_word(32'h200, pre[0]);
        put_word(32'h204, pre[1]);
        put_word(32'h20c, pre[2]);
        run_program();
        lb = {24'b0, pre[2][7:0]};
        hw = {16'b0, pre[2][31:16]};
        check_word("sb", mem_word(32'h200), (pre[0] & 32'hffff_00ff) | (32'hab << 8));
        check_word("sh", mem_word(32'h204), (pre[1] & 32'h0000_ffff) | (32'h5cd << 16));
        check_word("lb", mem_word(32'h210), {{24{lb[7]}}, lb[7:0]});
        check_word("lbu", mem_word(32'h214), lb);
        check_word("lh", mem_word(32'h218), {{16{hw[15]}}, hw[15:0]});
        check_word("lhu", mem_word(32'h21c), hw);
    endtask

    task automatic finish_test(string name, int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic arith_test();
        int e0;
        e0 = errors;
        arith_run();
        finish_test("arith", e0);
    endtask

    task automatic control_test();
        int e0;
        e0 = errors;
        control_run();
        finish_test("control", e0);
    endtask

    task automatic mem_size_test();
        int e0;
        e0 = errors;
        mem_size_run();
        finish_test("mem_size", e0);
    endtask

    task automatic backpressure_test();
        int e0;
        e0 = errors;
        delay_en = 1'b1;
        arith_run();
        control_run();
        mem_size_run();
        delay_en = 1'b0;
        finish_test("backpressure", e0);
    endtask

    task automatic halt_test();
        int e0;
        int fires;
        e0    = errors;
        fires = 0;
        prog  = {};
        prog.push_back(i_type(5, 0, 0, 1, OP_IMM));
        prog.push_back(s_type(12'h200, 1, 0, 2));
        prog.push_back(EBREAK);
        begin_load();
        run_program();
        check_word("halt_store", mem_word(32'h200), 32'd5);
        repeat (50) begin
            @(negedge clk);
            if ((axi_req.arvalid && axi_rsp.arready) || (axi_req.awvalid && axi_rsp.awready)) begin
                fires++;
            end
        end
        checks++;
        if (fires != 0 || !halted) begin
            errors++;
            $display("bus activity or loss of halt after ebreak (%0d transfers)", fires);
        end
        check_pc(pc, 32'h8);
        finish_test("halt", e0);
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        delay_en    = 1'b0;
        fill        = 1'b0;
        load_en     = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        cycle_count = 0;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        arith_test();
        control_test();
        mem_size_test();
        backpressure_test();
        halt_test();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
